/* src/gat_pkg.sv */
package gat_pkg;

  localparam int unsigned FEAT_ADDR_W = 16;
  localparam int unsigned FEAT_DATA_W = 32;
  localparam int unsigned LAYER_CNT_W = 4;

  localparam logic [FEAT_ADDR_W-1:0] LAYER_REGION   = 16'd4096;  // words per layer.
  localparam logic [FEAT_ADDR_W-1:0] OUT_ADDR_LIMIT = 16'd43328; // start of reserved area.

  localparam int unsigned H_NUM_SPARSE_DATA = 12;

  // ascii "GAT" over the sparse-data count.
  localparam logic [31:0] DBG_ID = {24'h474154, 8'(H_NUM_SPARSE_DATA)};

  typedef enum logic [2:0] {
    IDLE,
    DMVM,
    SPMM,
    SM,
    AGGR,
    DONE
  } stage_e;

  typedef struct packed {
    logic dmvm;
    logic spmm;
    logic sm;
    logic aggr;
  } stage_vec_t;

  typedef struct packed {
    logic                   ena;
    logic [FEAT_ADDR_W-1:0] addra;
    logic [FEAT_DATA_W-1:0] din;
  } feat_wr_t;

  typedef enum logic [2:0] {
    ID,
    FLAGS,
    SM_CNT,
    SNAP_A,
    SNAP_B
  } dbg_sel_e;

endpackage

/* src/layer_scheduler.sv */
`timescale 1ns/1ps

module layer_scheduler (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start_i,
  input  logic [gat_pkg::LAYER_CNT_W-1:0] layer_cnt_i,
  input  gat_pkg::stage_vec_t             stage_rdy_i,
  output gat_pkg::stage_vec_t             stage_vld_o,
  output logic [gat_pkg::LAYER_CNT_W-1:0] layer_o,
  output logic                            busy_o,
  output logic                            done_o
);

  import gat_pkg::*;

  stage_e                 state_q;
  stage_e                 state_d;
  stage_vec_t             vld_d;
  logic [LAYER_CNT_W-1:0] layer_q;
  logic [LAYER_CNT_W-1:0] layer_d;
  logic [LAYER_CNT_W-1:0] layer_max_q;
  logic [LAYER_CNT_W-1:0] layer_max_d;
  logic                   last_layer;
  logic                   stage_done;

  assign last_layer = (layer_q == layer_max_q - 1'b1);

  // only the running stage may advance the sequence.
  always_comb begin
    case (state_q)
      DMVM:    stage_done = stage_rdy_i.dmvm;
      SPMM:    stage_done = stage_rdy_i.spmm;
      SM:      stage_done = stage_rdy_i.sm;
      AGGR:    stage_done = stage_rdy_i.aggr;
      default: stage_done = 1'b0;
    endcase
  end

  always_comb begin
    state_d     = state_q;
    vld_d       = '0;
    layer_d     = layer_q;
    layer_max_d = layer_max_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          layer_d     = '0;
          layer_max_d = layer_cnt_i;
          if (layer_cnt_i == '0) begin
            state_d = DONE; // nothing to run.
          end else begin
            state_d    = DMVM;
            vld_d.dmvm = 1'b1;
          end
        end
      end
      DMVM: begin
        if (stage_done) begin
          state_d    = SPMM;
          vld_d.spmm = 1'b1;
        end
      end
      SPMM: begin
        if (stage_done) begin
          state_d  = SM;
          vld_d.sm = 1'b1;
        end
      end
      SM: begin
        if (stage_done) begin
          state_d    = AGGR;
          vld_d.aggr = 1'b1;
        end
      end
      AGGR: begin
        if (stage_done) begin
          if (last_layer) begin
            state_d = DONE;
          end else begin
            state_d    = DMVM; // next layer round.
            vld_d.dmvm = 1'b1;
            layer_d    = layer_q + 1'b1;
          end
        end
      end
      DONE: begin
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q     <= IDLE;
      stage_vld_o <= '0;
      layer_q     <= '0;
      layer_max_q <= '0;
    end else begin
      state_q     <= state_d;
      stage_vld_o <= vld_d;
      layer_q     <= layer_d;
      layer_max_q <= layer_max_d;
    end
  end

  assign layer_o = layer_q;
  assign busy_o  = (state_q != IDLE) && (state_q != DONE);
  assign done_o  = (state_q == DONE); // lasts the single DONE cycle.

endmodule

/* src/feat_writeback.sv */
`timescale 1ns/1ps

module feat_writeback (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            aggr_start_i,
  input  logic [gat_pkg::LAYER_CNT_W-1:0] layer_i,
  input  logic                            aggr_wr_i,
  input  logic [gat_pkg::FEAT_DATA_W-1:0] aggr_data_i,
  output gat_pkg::feat_wr_t               feat_wr_o
);

  import gat_pkg::*;

  logic [FEAT_ADDR_W-1:0] ord_q;
  logic [FEAT_ADDR_W-1:0] ord_cur;
  logic [FEAT_ADDR_W-1:0] region_base;
  logic                   wr_ena_q;
  logic [FEAT_ADDR_W-1:0] wr_addr_q;
  logic [FEAT_DATA_W-1:0] wr_data_q;

  // a start strobe restarts the ordinal in the same cycle.
  assign ord_cur     = aggr_start_i ? '0 : ord_q;
  assign region_base = FEAT_ADDR_W'(layer_i) * LAYER_REGION;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ord_q <= '0;
    end else if (aggr_wr_i) begin
      ord_q <= ord_cur + 1'b1;
    end else if (aggr_start_i) begin
      ord_q <= '0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ena_q <= 1'b0;
    end else begin
      wr_ena_q <= aggr_wr_i;
    end
  end

  always_ff @(posedge clk) begin
    if (aggr_wr_i) begin
      wr_addr_q <= region_base + ord_cur;
      wr_data_q <= aggr_data_i;
    end
  end

  assign feat_wr_o = '{ena: wr_ena_q, addra: wr_addr_q, din: wr_data_q};

endmodule

/* src/debug_monitor.sv */
`timescale 1ns/1ps

module debug_monitor (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            dbg_clr_i,
  input  gat_pkg::stage_vec_t             stage_vld_i,
  input  gat_pkg::stage_vec_t             stage_rdy_i,
  input  gat_pkg::feat_wr_t               feat_wr_i,
  input  logic [gat_pkg::FEAT_ADDR_W-1:0] watch_a_i,
  input  logic [gat_pkg::FEAT_ADDR_W-1:0] watch_b_i,
  input  gat_pkg::dbg_sel_e               dbg_sel_i,
  output logic [31:0]                     debug_o
);

  import gat_pkg::*;

  stage_vec_t             vld_flag_q;
  stage_vec_t             rdy_flag_q;
  logic                   wr_flag_q;
  logic                   ovf_flag_q;
  logic [31:0]            sm_cnt_q;
  logic [FEAT_DATA_W-1:0] snap_a_q;
  logic [FEAT_DATA_W-1:0] snap_b_q;
  logic                   ovf_hit;
  logic                   hit_a;
  logic                   hit_b;
  logic [31:0]            flags_word;

  assign ovf_hit = feat_wr_i.ena && (feat_wr_i.addra >= OUT_ADDR_LIMIT);
  assign hit_a   = feat_wr_i.ena && (feat_wr_i.addra == watch_a_i);
  assign hit_b   = feat_wr_i.ena && (feat_wr_i.addra == watch_b_i);

  // sticky event flags.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_flag_q <= '0;
      rdy_flag_q <= '0;
      wr_flag_q  <= 1'b0;
      ovf_flag_q <= 1'b0;
    end else if (dbg_clr_i) begin
      vld_flag_q <= '0;
      rdy_flag_q <= '0;
      wr_flag_q  <= 1'b0;
      ovf_flag_q <= 1'b0;
    end else begin
      vld_flag_q <= vld_flag_q | stage_vld_i;
      rdy_flag_q <= rdy_flag_q | stage_rdy_i; // stray dones count too.
      wr_flag_q  <= wr_flag_q | feat_wr_i.ena;
      ovf_flag_q <= ovf_flag_q | ovf_hit;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_cnt_q <= '0;
    end else if (dbg_clr_i) begin
      sm_cnt_q <= '0;
    end else if (stage_vld_i.sm) begin
      sm_cnt_q <= sm_cnt_q + 1'b1;
    end
  end

  // last data written at each watched address.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      snap_a_q <= '0;
      snap_b_q <= '0;
    end else if (dbg_clr_i) begin
      snap_a_q <= '0;
      snap_b_q <= '0;
    end else begin
      if (hit_a) begin
        snap_a_q <= feat_wr_i.din;
      end
      if (hit_b) begin
        snap_b_q <= feat_wr_i.din;
      end
    end
  end

  assign flags_word = {
    22'd0,
    ovf_flag_q,
    wr_flag_q,
    vld_flag_q.dmvm,
    rdy_flag_q.dmvm,
    vld_flag_q.spmm,
    rdy_flag_q.spmm,
    vld_flag_q.sm,
    rdy_flag_q.sm,
    vld_flag_q.aggr,
    rdy_flag_q.aggr
  };

  always_comb begin
    case (dbg_sel_i)
      ID:      debug_o = DBG_ID;
      FLAGS:   debug_o = flags_word;
      SM_CNT:  debug_o = sm_cnt_q;
      SNAP_A:  debug_o = snap_a_q;
      SNAP_B:  debug_o = snap_b_q;
      default: debug_o = '0; // unused select codes.
    endcase
  end

endmodule

/* src/gat_ctrl_top.sv */
`timescale 1ns/1ps

module gat_ctrl_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start_i,
  input  logic [gat_pkg::LAYER_CNT_W-1:0] layer_cnt_i,
  input  gat_pkg::stage_vec_t             stage_rdy_i,
  output gat_pkg::stage_vec_t             stage_vld_o,
  output logic                            busy_o,
  output logic                            done_o,
  input  logic                            aggr_wr_i,
  input  logic [gat_pkg::FEAT_DATA_W-1:0] aggr_data_i,
  output gat_pkg::feat_wr_t               feat_wr_o,
  input  logic                            dbg_clr_i,
  input  logic [gat_pkg::FEAT_ADDR_W-1:0] watch_a_i,
  input  logic [gat_pkg::FEAT_ADDR_W-1:0] watch_b_i,
  input  gat_pkg::dbg_sel_e               dbg_sel_i,
  output logic [31:0]                     debug_o
);

  import gat_pkg::*;

  stage_vec_t             stage_vld;
  logic [LAYER_CNT_W-1:0] layer;
  feat_wr_t               feat_wr;

  layer_scheduler u_scheduler (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .layer_cnt_i (layer_cnt_i),
    .stage_rdy_i (stage_rdy_i),
    .stage_vld_o (stage_vld),
    .layer_o     (layer),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // aggregation start strobe restarts the write ordinal.
  feat_writeback u_writeback (
    .clk          (clk),
    .rst_n        (rst_n),
    .aggr_start_i (stage_vld.aggr),
    .layer_i      (layer),
    .aggr_wr_i    (aggr_wr_i),
    .aggr_data_i  (aggr_data_i),
    .feat_wr_o    (feat_wr)
  );

  debug_monitor u_monitor (
    .clk         (clk),
    .rst_n       (rst_n),
    .dbg_clr_i   (dbg_clr_i),
    .stage_vld_i (stage_vld),
    .stage_rdy_i (stage_rdy_i),
    .feat_wr_i   (feat_wr),
    .watch_a_i   (watch_a_i),
    .watch_b_i   (watch_b_i),
    .dbg_sel_i   (dbg_sel_i),
    .debug_o     (debug_o)
  );

  assign stage_vld_o = stage_vld;
  assign feat_wr_o   = feat_wr;

endmodule

/* tests/gat_ctrl_sva.sv */
`timescale 1ns/1ps

module gat_ctrl_sva (
  input logic                clk,
  input logic                rst_n,
  input gat_pkg::stage_vec_t stage_vld_i,
  input logic                busy_i,
  input logic                done_i
);

  // one stage start at a time.
  a_strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(stage_vld_i))
    else $error("more than one stage strobe high in one cycle");

  a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
    done_i |=> !done_i)
    else $error("done_o held high for more than one cycle");

  a_strobe_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (stage_vld_i != '0) |-> busy_i)
    else $error("stage strobe issued while busy_o is low");

endmodule

bind layer_scheduler gat_ctrl_sva u_sva (
  .clk         (clk),
  .rst_n       (rst_n),
  .stage_vld_i (stage_vld_o),
  .busy_i      (busy_o),
  .done_i      (done_o)
);

/* tests/tb_gat_ctrl_top.sv */
`timescale 1ns/1ps

module tb_gat_ctrl_top;

  import gat_pkg::*;

  localparam int HALF_PERIOD  = 10;
  localparam int RUNS         = 20;
  localparam int WAIT_LIMIT   = 32;
  localparam int REGION_WORDS = 4096;
  localparam int OVF_LIMIT    = 43328;

  logic                   clk;
  logic                   rst_n;
  logic                   start_i;
  logic [LAYER_CNT_W-1:0] layer_cnt_i;
  stage_vec_t             stage_rdy_i;
  stage_vec_t             stage_vld_o;
  logic                   busy_o;
  logic                   done_o;
  logic                   aggr_wr_i;
  logic [FEAT_DATA_W-1:0] aggr_data_i;
  feat_wr_t               feat_wr_o;
  logic                   dbg_clr_i;
  logic [FEAT_ADDR_W-1:0] watch_a_i;
  logic [FEAT_ADDR_W-1:0] watch_b_i;
  dbg_sel_e               dbg_sel_i;
  logic [31:0]            debug_o;

  integer seed;
  int     errors;
  int     timeouts;
  int     strobe_cnt;
  logic   prev_wr;

  logic [3:0]                         m_vld;  // reference model.
  logic [3:0]                         m_rdy;
  logic                               m_wr;
  logic                               m_ovf;
  logic [31:0]                        m_sm_cnt;
  logic [31:0]                        m_snap_a;
  logic [31:0]                        m_snap_b;
  int                                 m_layer;
  logic [FEAT_ADDR_W-1:0]             w_a;
  logic [FEAT_ADDR_W-1:0]             w_b;
  logic [FEAT_ADDR_W+FEAT_DATA_W-1:0] exp_wr_q[$];

  gat_ctrl_top gat_ctrl_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .layer_cnt_i (layer_cnt_i),
    .stage_rdy_i (stage_rdy_i),
    .stage_vld_o (stage_vld_o),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .aggr_wr_i   (aggr_wr_i),
    .aggr_data_i (aggr_data_i),
    .feat_wr_o   (feat_wr_o),
    .dbg_clr_i   (dbg_clr_i),
    .watch_a_i   (watch_a_i),
    .watch_b_i   (watch_b_i),
    .dbg_sel_i   (dbg_sel_i),
    .debug_o     (debug_o)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  function automatic int unsigned urand(input int unsigned n);
    int unsigned r;
    r = $unsigned($random(seed));
    return r % n;
  endfunction

  function automatic logic [3:0] stage_mask(input int idx);
    return 4'b1000 >> idx; // dmvm, spmm, sm, aggr.
  endfunction

  function automatic logic [FEAT_ADDR_W-1:0] pick_watch(input int cnt);
    int layer;
    if (cnt == 0) begin
      return FEAT_ADDR_W'(urand(4));
    end
    layer = int'(urand(cnt));
    return FEAT_ADDR_W'(layer * REGION_WORDS + int'(urand(3)));
  endfunction

  function automatic logic [31:0] model_flags();
    return {22'd0, m_ovf, m_wr, m_vld[3], m_rdy[3], m_vld[2], m_rdy[2],
            m_vld[1], m_rdy[1], m_vld[0], m_rdy[0]};
  endfunction

  task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic clear_model();
    m_vld    = '0;
    m_rdy    = '0;
    m_wr     = 1'b0;
    m_ovf    = 1'b0;
    m_sm_cnt = '0;
    m_snap_a = '0;
    m_snap_b = '0;
  endtask

  task automatic note_write(input logic [FEAT_ADDR_W-1:0] addr, input logic [31:0] data);
    m_wr = 1'b1;
    if (int'(addr) >= OVF_LIMIT) begin
      m_ovf = 1'b1;
    end
    if (addr == w_a) begin
      m_snap_a = data;
    end
    if (addr == w_b) begin
      m_snap_b = data;
    end
  endtask

  task automatic wait_strobe(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (stage_vld_o == '0 && cycles < WAIT_LIMIT);
  endtask

  task automatic wait_done(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!done_o && cycles < WAIT_LIMIT);
  endtask

  // stage engine stand-in with stray dones and starts while busy.
  task automatic respond(input int idx);
    logic [3:0]             mask;
    logic [3:0]             stray;
    logic [31:0]            data;
    logic [FEAT_ADDR_W-1:0] addr;
    int                     n_wr;
    int                     dly;
    mask = stage_mask(idx);
    if (idx == 3) begin
      n_wr = int'(urand(6));
      for (int i = 0; i < n_wr; i++) begin
        data = $random(seed);
        addr = FEAT_ADDR_W'(m_layer * REGION_WORDS + i);
        aggr_wr_i   <= 1'b1;
        aggr_data_i <= data;
        exp_wr_q.push_back({addr, data});
        note_write(addr, data);
        @(posedge clk);
      end
      aggr_wr_i <= 1'b0;
    end
    dly = 1 + int'(urand(8));
    for (int i = 0; i < dly; i++) begin
      stray = 4'($random(seed)) & ~mask;
      if (urand(3) != 0) begin
        stray = 4'b0000;
      end
      stage_rdy_i <= stage_vec_t'(stray);
      m_rdy = m_rdy | stray;
      start_i     <= (urand(6) == 0);
      layer_cnt_i <= LAYER_CNT_W'(urand(16));
      @(posedge clk);
    end
    stage_rdy_i <= stage_vec_t'(mask);
    start_i     <= 1'b0;
    m_rdy = m_rdy | mask;
    @(posedge clk);
    stage_rdy_i <= '0;
  endtask

  task automatic run_job(input int cnt, output bit ok);
    int cycles;
    int base_cnt;
    ok = 1'b1;
    base_cnt = strobe_cnt;
    w_a = pick_watch(cnt);
    w_b = pick_watch(cnt);
    watch_a_i   <= w_a;
    watch_b_i   <= w_b;
    layer_cnt_i <= LAYER_CNT_W'(cnt);
    start_i     <= 1'b1;
    @(posedge clk);
    start_i     <= 1'b0;
    layer_cnt_i <= LAYER_CNT_W'(urand(16)); // count is latched at start.
    for (int layer = 0; layer < cnt; layer++) begin
      m_layer = layer;
      for (int idx = 0; idx < 4; idx++) begin
        wait_strobe(cycles);
        if (stage_vld_o == '0) begin
          $display("timeout: no stage strobe in layer %0d, stage %0d", layer, idx);
          timeouts++;
          ok = 1'b0;
          return;
        end
        check_eq("strobe latency", 32'(cycles), 32'd1);
        check_eq("stage strobe", 32'(stage_vld_o), 32'(stage_mask(idx)));
        check_eq("busy in stage", 32'(busy_o), 32'd1);
        m_vld = m_vld | stage_mask(idx);
        if (idx == 2) begin
          m_sm_cnt++;
        end
        respond(idx);
      end
    end
    wait_done(cycles);
    if (!done_o) begin
      $display("timeout: done_o did not pulse for a run of %0d layers", cnt);
      timeouts++;
      ok = 1'b0;
      return;
    end
    check_eq("done latency", 32'(cycles), 32'd1);
    check_eq("busy at done", 32'(busy_o), 32'd0);
    @(posedge clk);
    check_eq("done width", 32'(done_o), 32'd0);
    check_eq("strobe count", 32'(strobe_cnt - base_cnt), 32'(4 * cnt));
  endtask

  task automatic read_dbg(input dbg_sel_e sel, output logic [31:0] val);
    dbg_sel_i <= sel;
    @(posedge clk);
    val = debug_o;
  endtask

  task automatic check_readout();
    logic [31:0] val;
    read_dbg(ID, val);
    check_eq("ID word", val, DBG_ID);
    check_eq("ID sparse count", 32'(val[7:0]), 32'd12);
    read_dbg(FLAGS, val);
    check_eq("FLAGS word", val, model_flags());
    read_dbg(SM_CNT, val);
    check_eq("SM_CNT word", val, m_sm_cnt);
    read_dbg(SNAP_A, val);
    check_eq("SNAP_A word", val, m_snap_a);
    read_dbg(SNAP_B, val);
    check_eq("SNAP_B word", val, m_snap_b);
    read_dbg(dbg_sel_e'(3'd7), val);
    check_eq("unused select", val, 32'd0);
  endtask

  task automatic clear_and_check();
    logic [31:0] val;
    dbg_clr_i <= 1'b1;
    @(posedge clk);
    dbg_clr_i <= 1'b0;
    clear_model();
    read_dbg(FLAGS, val);
    check_eq("FLAGS after clear", val, 32'd0);
    read_dbg(SM_CNT, val);
    check_eq("SM_CNT after clear", val, 32'd0);
    read_dbg(SNAP_A, val);
    check_eq("SNAP_A after clear", val, 32'd0);
    read_dbg(SNAP_B, val);
    check_eq("SNAP_B after clear", val, 32'd0);
  endtask

  task automatic end_of_test();
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // each write must follow its strobe by one cycle.
  always @(posedge clk) begin : wr_monitor
    logic [FEAT_ADDR_W+FEAT_DATA_W-1:0] exp_wr;
    if (!rst_n) begin
      prev_wr = 1'b0;
    end else begin
      check_eq("write enable", 32'(feat_wr_o.ena), 32'(prev_wr));
      if (feat_wr_o.ena && exp_wr_q.size() == 0) begin
        errors++;
        $display("unexpected feature write at %0t ns with nothing queued", $time);
      end else if (feat_wr_o.ena) begin
        exp_wr = exp_wr_q.pop_front();
        check_eq("write address", 32'(feat_wr_o.addra),
                 32'(exp_wr[FEAT_ADDR_W+FEAT_DATA_W-1:FEAT_DATA_W]));
        check_eq("write data", feat_wr_o.din, exp_wr[FEAT_DATA_W-1:0]);
      end
      prev_wr = aggr_wr_i;
      if (stage_vld_o != '0) begin
        strobe_cnt++;
      end
    end
  end

  initial begin
    int cnt;
    bit ok;
    bit stop;
    rst_n       = 1'b0;
    start_i     = 1'b0;
    layer_cnt_i = '0;
    stage_rdy_i = '0;
    aggr_wr_i   = 1'b0;
    aggr_data_i = '0;
    dbg_clr_i   = 1'b0;
    watch_a_i   = '0;
    watch_b_i   = '0;
    dbg_sel_i   = ID;
    seed        = 29439;
    errors      = 0;
    timeouts    = 0;
    strobe_cnt  = 0;
    stop        = 1'b0;
    m_layer     = 0;
    w_a         = '0;
    w_b         = '0;
    clear_model();
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_eq("strobes after reset", 32'(stage_vld_o), 32'd0);
    check_eq("busy after reset", 32'(busy_o), 32'd0);
    check_eq("done after reset", 32'(done_o), 32'd0);
    check_eq("write after reset", 32'(feat_wr_o.ena), 32'd0);
    for (int run = 0; run < RUNS && !stop; run++) begin
      if (run == 0) begin
        cnt = 15; // reaches the reserved region.
      end else if (run % 5 == 4) begin
        cnt = 0;
      end else begin
        cnt = 1 + int'(urand(15));
      end
      run_job(cnt, ok);
      if (!ok) begin
        stop = 1'b1;
      end else begin
        check_readout();
        if (urand(3) == 0) begin
          clear_and_check();
        end
      end
    end
    end_of_test();
  end

endmodule

/* src.f */
src/gat_pkg.sv
src/layer_scheduler.sv
src/feat_writeback.sv
src/debug_monitor.sv
src/gat_ctrl_top.sv
tests/gat_ctrl_sva.sv
tests/tb_gat_ctrl_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_gat_ctrl_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
